/* cp0_regs.sv */
`timescale 1ns/10ps

module cp0_regs (
    input  logic                            clk,
    input  logic                            reset,
    reg_wr_if.cp0                           wr,
    input  logic [regs_pkg::IDX_W-1:0]      rd_idx,
    output regs_pkg::word_t                 rd_data,
    input  logic                            exc_valid,
    input  regs_pkg::exc_code_e             exc_code,
    input  regs_pkg::word_t                 exc_epc,
    input  regs_pkg::word_t                 exc_badaddr,
    input  logic                            exc_bd,
    input  logic                            eret,
    input  logic [regs_pkg::HW_INT_W-1:0]   hw_int,
    output regs_pkg::word_t                 status,
    output regs_pkg::word_t                 cause,
    output regs_pkg::word_t                 epc,
    output logic                            irq_pending
);
    import regs_pkg::*;

    // status fields
    logic               st_ie;
    logic               st_exl;
    logic [7:0]         st_im;
    // cause fields
    logic               ca_bd;
    logic [HW_INT_W-1:0] ca_ip_hw;
    logic [1:0]         ca_ip_sw;
    exc_code_e          ca_exc;
    // full words
    word_t              epc_q;
    word_t              badvaddr_q;

    logic               mtc0;
    logic [IDX_W-1:0]   wr_idx;
    logic               addr_err;
    logic [7:0]         ip;

    assign mtc0     = wr.we & (wr.cls == CLASS_CP0);
    assign wr_idx   = wr.addr[IDX_W-1:0];
    // only address errors capture the faulting address
    assign addr_err = (exc_code == EXC_ADEL) | (exc_code == EXC_ADES);

    always_ff @(posedge clk) begin
        if (reset) begin
            st_ie      <= 1'b0;
            st_exl     <= 1'b0;
            st_im      <= '0;
            ca_bd      <= 1'b0;
            ca_ip_hw   <= '0;
            ca_ip_sw   <= '0;
            ca_exc     <= EXC_INT;
            epc_q      <= '0;
            badvaddr_q <= '0;
        end else begin
            // pins sampled every cycle, one cycle late in cause
            ca_ip_hw <= hw_int;
            if (exc_valid) begin
                // exception entry, mtc0 and eret lose this cycle
                st_exl <= 1'b1;
                ca_exc <= exc_code;
                ca_bd  <= exc_bd;
                epc_q  <= exc_epc;
                if (addr_err) begin
                    badvaddr_q <= exc_badaddr;
                end
            end else begin
                if (mtc0) begin
                    case (wr_idx)
                        CP0_STATUS: begin
                            st_ie  <= wr.data[STATUS_IE];
                            st_exl <= wr.data[STATUS_EXL];
                            st_im  <= wr.data[STATUS_IM_LSB +: 8];
                        end
                        // software ip bits only
                        CP0_CAUSE: ca_ip_sw <= wr.data[CAUSE_IP_LSB +: 2];
                        CP0_EPC:   epc_q    <= wr.data;
                        // badvaddr and unknown indices read only
                        default: ;
                    endcase
                end
                // eret after mtc0 so it owns exl
                if (eret) begin
                    st_exl <= 1'b0;
                end
            end
        end
    end

    assign ip = {ca_ip_hw, ca_ip_sw};

    // assemble architectural words
    always_comb begin
        status                         = '0;
        status[STATUS_IE]              = st_ie;
        status[STATUS_EXL]             = st_exl;
        status[STATUS_IM_LSB +: 8]     = st_im;
        cause                          = '0;
        cause[CAUSE_BD]                = ca_bd;
        cause[CAUSE_IP_LSB +: 8]       = ip;
        cause[CAUSE_EXC_LSB +: 5]      = ca_exc;
    end

    assign epc = epc_q;

    // pending and unmasked, interrupts on, not already in a handler
    assign irq_pending = st_ie & ~st_exl & (|(ip & st_im));

    always_comb begin
        case (rd_idx)
            CP0_BADVADDR: rd_data = badvaddr_q;
            CP0_STATUS:   rd_data = status;
            CP0_CAUSE:    rd_data = cause;
            CP0_EPC:      rd_data = epc_q;
            default:      rd_data = '0;
        endcase
    end

endmodule

/* flist.f */
regs_pkg.sv
reg_wr_if.sv
write_port.sv
gpr_bank.sv
hilo_regs.sv
cp0_regs.sv
operand_read.sv
regfile_top.sv
regfile_props.sv
tb_regfile.sv

/* gpr_bank.sv */
`timescale 1ns/10ps

module gpr_bank (
    reg_wr_if.gpr                   wr,
    input  logic                    clk,
    input  logic [regs_pkg::IDX_W-1:0] rd_addr_1,
    input  logic [regs_pkg::IDX_W-1:0] rd_addr_2,
    output regs_pkg::word_t         rd_data_1,
    output regs_pkg::word_t         rd_data_2
);
    import regs_pkg::*;

    // 32 entries, entry 0 kept at zero
    word_t regs [0:31];
    logic  gpr_we;

    assign gpr_we = wr.we & (wr.cls == CLASS_GPR);

    always_ff @(posedge clk) begin
        if (gpr_we) begin
            regs[wr.addr[IDX_W-1:0]] <= wr.data;
        end
        // r0 rewritten every clock, last assignment wins
        regs[0] <= '0;
    end

    // asynchronous reads
    assign rd_data_1 = regs[rd_addr_1];
    assign rd_data_2 = regs[rd_addr_2];

endmodule

/* hilo_regs.sv */
`timescale 1ns/10ps

module hilo_regs (
    input  logic            clk,
    reg_wr_if.hilo          wr,
    output regs_pkg::word_t hi,
    output regs_pkg::word_t lo
);
    import regs_pkg::*;

    logic single_we;

    // single mthi/mtlo style write
    assign single_we = wr.we & (wr.cls == CLASS_HILO);

    always_ff @(posedge clk) begin
        if (wr.hl_we) begin
            // wide result beats a single write
            hi <= wr.hl_data[2*WORD_W-1:WORD_W];
            lo <= wr.hl_data[WORD_W-1:0];
        end else if (single_we) begin
            // only 7'h7f is hi, any other hilo address is lo
            if (wr.addr == ADDR_HI) begin
                hi <= wr.data;
            end else begin
                lo <= wr.data;
            end
        end
    end

endmodule

/* operand_read.sv */
`timescale 1ns/10ps

module operand_read (
    reg_wr_if.fwd                       wr,
    input  regs_pkg::raddr_t            rd_addr_1,
    input  regs_pkg::raddr_t            rd_addr_2,
    input  regs_pkg::word_t             hi,
    input  regs_pkg::word_t             lo,
    input  regs_pkg::word_t             gpr_data_1,
    input  regs_pkg::word_t             gpr_data_2,
    input  regs_pkg::word_t             cp0_data,
    output logic [regs_pkg::IDX_W-1:0]  gpr_addr_1,
    output logic [regs_pkg::IDX_W-1:0]  gpr_addr_2,
    output logic [regs_pkg::IDX_W-1:0]  cp0_idx,
    output regs_pkg::word_t             rd_data_1,
    output regs_pkg::word_t             rd_data_2
);
    import regs_pkg::*;

    // shared source selection for both ports
    function automatic word_t pick(raddr_t a, word_t gpr_val, word_t cp0_val);
        reg_class_e c;
        c = class_of(a);
        // same-cycle single write first
        if (wr.we && (wr.addr == a)) begin
            return wr.data;
        end
        if (c == CLASS_HILO) begin
            // wide mul/div result in flight
            if (wr.hl_we) begin
                return (a == ADDR_HI) ? wr.hl_data[2*WORD_W-1:WORD_W]
                                      : wr.hl_data[WORD_W-1:0];
            end
            return (a == ADDR_HI) ? hi : lo;
        end
        if (c == CLASS_CP0) begin
            return cp0_val;
        end
        return gpr_val;
    endfunction

    // index fields straight from the addresses
    assign gpr_addr_1 = rd_addr_1[IDX_W-1:0];
    assign gpr_addr_2 = rd_addr_2[IDX_W-1:0];
    // cp0 is only wired to port 2
    assign cp0_idx    = rd_addr_2[IDX_W-1:0];

    always_comb begin
        // port 1 sees zero for cp0 addresses
        rd_data_1 = pick(rd_addr_1, gpr_data_1, '0);
        rd_data_2 = pick(rd_addr_2, gpr_data_2, cp0_data);
    end

endmodule

/* reg_wr_if.sv */
`timescale 1ns/10ps

interface reg_wr_if;
    import regs_pkg::*;

    // single register write, already classified
    logic       we;
    reg_class_e cls;
    raddr_t     addr;
    word_t      data;
    // wide mul/div result
    logic       hl_we;
    hl_t        hl_data;

    modport src  (output we, cls, addr, data, hl_we, hl_data);
    modport gpr  (input we, cls, addr, data);
    modport hilo (input we, cls, addr, data, hl_we, hl_data);
    modport cp0  (input we, cls, addr, data);
    // forwarding needs the whole bus
    modport fwd  (input we, cls, addr, data, hl_we, hl_data);

endinterface

/* regfile_props.sv */
`timescale 1ns/10ps

module regfile_props (
    input logic             clk,
    input logic             reset,
    input logic             write_en,
    input regs_pkg::raddr_t write_addr,
    input regs_pkg::raddr_t read_addr_1,
    input regs_pkg::raddr_t read_addr_2,
    input regs_pkg::word_t  read_data_1,
    input regs_pkg::word_t  read_data_2,
    input logic             exc_valid,
    input regs_pkg::word_t  exc_epc,
    input logic             eret,
    input regs_pkg::word_t  status,
    input regs_pkg::word_t  epc,
    input logic             irq_pending
);
    import regs_pkg::*;

    // exl stays set without eret or mtc0 to status
    // so no request may appear in the next cycle
    irq_not_in_exl: assert property (@(posedge clk) disable iff (reset)
        (status[STATUS_EXL] && !eret && !(write_en && (write_addr == {2'b01, CP0_STATUS})))
        |=> !irq_pending)
        else $error("irq_pending rose while EXL was set");

    // r0 writes are dropped, so nothing forwards to address 0
    r0_zero_1: assert property (@(posedge clk) disable iff (reset)
        (read_addr_1 == '0) |-> (read_data_1 == '0))
        else $error("port 1 read of r0 was not zero");
    r0_zero_2: assert property (@(posedge clk) disable iff (reset)
        (read_addr_2 == '0) |-> (read_data_2 == '0))
        else $error("port 2 read of r0 was not zero");

    // exception entry lands one cycle later
    exc_entry: assert property (@(posedge clk) disable iff (reset)
        exc_valid |=> (status[STATUS_EXL] && (epc == $past(exc_epc))))
        else $error("exception entry did not set EXL and EPC");

endmodule

bind regfile_top regfile_props i_regfile_props (
    .clk         (clk),
    .reset       (reset),
    .write_en    (write_en),
    .write_addr  (write_addr),
    .read_addr_1 (read_addr_1),
    .read_addr_2 (read_addr_2),
    .read_data_1 (read_data_1),
    .read_data_2 (read_data_2),
    .exc_valid   (exc_valid),
    .exc_epc     (exc_epc),
    .eret        (eret),
    .status      (status),
    .epc         (epc),
    .irq_pending (irq_pending)
);

/* regfile_top.sv */
`timescale 1ns/10ps

module regfile_top (
    input  logic                            clk,
    input  logic                            reset,
    // writeback side
    input  logic                            write_en,
    input  regs_pkg::raddr_t                write_addr,
    input  regs_pkg::word_t                 write_data,
    input  logic                            hl_we,
    input  regs_pkg::hl_t                   hl_data,
    // decode side
    input  regs_pkg::raddr_t                read_addr_1,
    input  regs_pkg::raddr_t                read_addr_2,
    output regs_pkg::word_t                 read_data_1,
    output regs_pkg::word_t                 read_data_2,
    // exception and interrupt side
    input  logic                            exc_valid,
    input  regs_pkg::exc_code_e             exc_code,
    input  regs_pkg::word_t                 exc_epc,
    input  regs_pkg::word_t                 exc_badaddr,
    input  logic                            exc_bd,
    input  logic                            eret,
    input  logic [regs_pkg::HW_INT_W-1:0]   hw_int,
    output regs_pkg::word_t                 status,
    output regs_pkg::word_t                 cause,
    output regs_pkg::word_t                 epc,
    output logic                            irq_pending
);
    import regs_pkg::*;

    word_t            hi;
    word_t            lo;
    logic [IDX_W-1:0] gpr_addr_1;
    logic [IDX_W-1:0] gpr_addr_2;
    word_t            gpr_data_1;
    word_t            gpr_data_2;
    logic [IDX_W-1:0] cp0_idx;
    word_t            cp0_data;

    // decoded writeback bus
    reg_wr_if i_wr_bus ();

    write_port i_write_port (
        .write_en   (write_en),
        .write_addr (write_addr),
        .write_data (write_data),
        .hl_we      (hl_we),
        .hl_data    (hl_data),
        .wr         (i_wr_bus.src)
    );

    gpr_bank i_gpr_bank (
        .wr        (i_wr_bus.gpr),
        .clk       (clk),
        .rd_addr_1 (gpr_addr_1),
        .rd_addr_2 (gpr_addr_2),
        .rd_data_1 (gpr_data_1),
        .rd_data_2 (gpr_data_2)
    );

    hilo_regs i_hilo_regs (
        .clk (clk),
        .wr  (i_wr_bus.hilo),
        .hi  (hi),
        .lo  (lo)
    );

    cp0_regs i_cp0_regs (
        .clk         (clk),
        .reset       (reset),
        .wr          (i_wr_bus.cp0),
        .rd_idx      (cp0_idx),
        .rd_data     (cp0_data),
        .exc_valid   (exc_valid),
        .exc_code    (exc_code),
        .exc_epc     (exc_epc),
        .exc_badaddr (exc_badaddr),
        .exc_bd      (exc_bd),
        .eret        (eret),
        .hw_int      (hw_int),
        .status      (status),
        .cause       (cause),
        .epc         (epc),
        .irq_pending (irq_pending)
    );

    // two read ports with forwarding
    operand_read i_operand_read (
        .wr         (i_wr_bus.fwd),
        .rd_addr_1  (read_addr_1),
        .rd_addr_2  (read_addr_2),
        .hi         (hi),
        .lo         (lo),
        .gpr_data_1 (gpr_data_1),
        .gpr_data_2 (gpr_data_2),
        .cp0_data   (cp0_data),
        .gpr_addr_1 (gpr_addr_1),
        .gpr_addr_2 (gpr_addr_2),
        .cp0_idx    (cp0_idx),
        .rd_data_1  (read_data_1),
        .rd_data_2  (read_data_2)
    );

endmodule

/* regs_pkg.sv */
package regs_pkg;

    // basic widths, fixed by the instruction set
    localparam int WORD_W   = 32;
    localparam int ADDR_W   = 7;
    localparam int IDX_W    = 5;
    localparam int HW_INT_W = 6;

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [ADDR_W-1:0]   raddr_t;
    // hi sits in the upper half
    typedef logic [2*WORD_W-1:0] hl_t;

    // canonical hi and lo addresses
    localparam raddr_t ADDR_HI = 7'h7f;
    localparam raddr_t ADDR_LO = 7'h40;

    // address bits selecting the register class
    localparam int ADDR_HILO_BIT = 6;
    localparam int ADDR_CP0_BIT  = 5;

    typedef enum logic [1:0] {
        CLASS_GPR,
        CLASS_CP0,
        CLASS_HILO
    } reg_class_e;

    // implemented cp0 indices only
    typedef enum logic [IDX_W-1:0] {
        CP0_BADVADDR = 5'd8,
        CP0_STATUS   = 5'd12,
        CP0_CAUSE    = 5'd13,
        CP0_EPC      = 5'd14
    } cp0_idx_e;

    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_SYS  = 5'd8,
        EXC_BP   = 5'd9,
        EXC_RI   = 5'd10,
        EXC_OV   = 5'd12
    } exc_code_e;

    // status bit positions
    localparam int STATUS_IE     = 0;
    localparam int STATUS_EXL    = 1;
    localparam int STATUS_IM_LSB = 8;

    // cause bit positions
    localparam int CAUSE_EXC_LSB = 2;
    localparam int CAUSE_IP_LSB  = 8;
    localparam int CAUSE_BD      = 31;

    // hi/lo wins over cp0 when both class bits are set
    function automatic reg_class_e class_of(raddr_t a);
        if (a[ADDR_HILO_BIT]) begin
            return CLASS_HILO;
        end
        if (a[ADDR_CP0_BIT]) begin
            return CLASS_CP0;
        end
        return CLASS_GPR;
    endfunction

endpackage

/* run.sh */
#!/bin/sh
# build with verilator, run, and look for the pass line in the output
verilator --binary --timing --assert --top-module tb_regfile -f flist.f \
    && ./obj_dir/Vtb_regfile | tee /dev/stderr | grep -q "TB PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* tb_regfile.sv */
`timescale 1ns/10ps

module tb_regfile;
    import regs_pkg::*;

    // one stimulus row, drives plus the read check enable
    typedef struct packed {
        logic       we;
        raddr_t     waddr;
        word_t      wdata;
        logic       hl_we;
        hl_t        hl_data;
        logic       exc;
        exc_code_e  code;
        word_t      exc_epc;
        word_t      exc_bad;
        logic       bd;
        logic       eret;
        logic [5:0] hw_int;
        raddr_t     ra1;
        raddr_t     ra2;
        logic       chk;
    } row_t;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        write_en, hl_we, exc_valid, exc_bd, eret, irq_pending;
    raddr_t      write_addr, read_addr_1, read_addr_2;
    word_t       write_data, exc_epc, exc_badaddr;
    word_t       read_data_1, read_data_2, status, cause, epc;
    hl_t         hl_data;
    exc_code_e   exc_code;
    logic [5:0]  hw_int;

    row_t        row_q [$];
    string       name_q [$];
    logic [31:0] lfsr = 32'h3f8f;

    // shadow of the architectural state
    word_t       sh_gpr [0:31];
    word_t       sh_hi, sh_lo, sh_epc, sh_bva;
    logic        sh_ie, sh_exl, sh_bd;
    logic [7:0]  sh_im;
    logic [5:0]  sh_iphw;
    logic [1:0]  sh_ipsw;
    exc_code_e   sh_exc;

    regfile_top i_regfile_top (.*);

    // 8 ns period
    always #4 clk = ~clk;

    initial begin
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
    end

    // galois lfsr, one step per bit taken
    function automatic word_t lfsr_bits(int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic stop_run();
        $display("TB FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            stop_run();
        end
    endtask

    // status: im 15:8, exl 1, ie 0
    function automatic word_t status_word();
        return {16'h0, sh_im, 6'h0, sh_exl, sh_ie};
    endfunction

    // cause: bd 31, ip 15:8, exccode 6:2
    function automatic word_t cause_word();
        return {sh_bd, 15'h0, sh_iphw, sh_ipsw, 1'b0, sh_exc, 2'b00};
    endfunction

    function automatic word_t cp0_word(logic [4:0] idx);
        case (idx)
            5'd8:    return sh_bva;
            5'd12:   return status_word();
            5'd13:   return cause_word();
            5'd14:   return sh_epc;
            default: return '0;
        endcase
    endfunction

    function automatic logic irq_level();
        return sh_ie & ~sh_exl & (|({sh_iphw, sh_ipsw} & sh_im));
    endfunction

    // expected read value, sources in priority order
    function automatic word_t predict_read(row_t r, raddr_t a, logic port2);
        // same-cycle single write, r0 never forwards
        if (r.we && (r.waddr != '0) && (r.waddr == a)) begin
            return r.wdata;
        end
        if (a[6]) begin
            if (r.hl_we) begin
                return (a == 7'h7f) ? r.hl_data[63:32] : r.hl_data[31:0];
            end
            return (a == 7'h7f) ? sh_hi : sh_lo;
        end
        // cp0 only on port 2
        if (a[5]) begin
            return port2 ? cp0_word(a[4:0]) : '0;
        end
        return (a[4:0] == 5'd0) ? '0 : sh_gpr[a[4:0]];
    endfunction

    // state update at the clock edge after a row
    task automatic shadow_step(row_t r);
        logic [4:0] idx;
        idx = r.waddr[4:0];
        if (r.we && !r.waddr[6] && !r.waddr[5] && (idx != 5'd0)) begin
            sh_gpr[idx] = r.wdata;
        end
        // wide result beats single hi/lo write
        if (r.hl_we) begin
            sh_hi = r.hl_data[63:32];
            sh_lo = r.hl_data[31:0];
        end else if (r.we && r.waddr[6]) begin
            if (r.waddr == 7'h7f) begin
                sh_hi = r.wdata;
            end else begin
                sh_lo = r.wdata;
            end
        end
        sh_iphw = r.hw_int;
        if (r.exc) begin
            sh_exl = 1'b1;
            sh_exc = r.code;
            sh_bd  = r.bd;
            sh_epc = r.exc_epc;
            if ((r.code == EXC_ADEL) || (r.code == EXC_ADES)) begin
                sh_bva = r.exc_bad;
            end
        end else begin
            if (r.we && !r.waddr[6] && r.waddr[5]) begin
                case (idx)
                    5'd12: begin
                        sh_ie  = r.wdata[0];
                        sh_exl = r.wdata[1];
                        sh_im  = r.wdata[15:8];
                    end
                    5'd13:   sh_ipsw = r.wdata[9:8];
                    5'd14:   sh_epc = r.wdata;
                    default: ;
                endcase
            end
            if (r.eret) begin
                sh_exl = 1'b0;
            end
        end
    endtask

    function automatic row_t make_row(logic we, raddr_t wa, word_t wd, raddr_t ra1,
                                      raddr_t ra2, logic [5:0] hw);
        row_t r;
        r = '0;
        r.code   = EXC_INT;
        r.we     = we;
        r.waddr  = wa;
        r.wdata  = wd;
        r.ra1    = ra1;
        r.ra2    = ra2;
        r.hw_int = hw;
        r.chk    = 1'b1;
        return r;
    endfunction

    function automatic row_t exc_row(logic exc, exc_code_e code, word_t pc, word_t bad,
                                     logic bd, logic er, raddr_t ra2);
        row_t r;
        r = make_row(1'b0, '0, '0, '0, ra2, 6'h00);
        r.exc     = exc;
        r.code    = code;
        r.exc_epc = pc;
        r.exc_bad = bad;
        r.bd      = bd;
        r.eret    = er;
        return r;
    endfunction

    task automatic add_row(string name, row_t r);
        row_q.push_back(r);
        name_q.push_back(name);
    endtask

    task automatic apply_row(row_t r);
        write_en    = r.we;
        write_addr  = r.waddr;
        write_data  = r.wdata;
        hl_we       = r.hl_we;
        hl_data     = r.hl_data;
        exc_valid   = r.exc;
        exc_code    = r.code;
        exc_epc     = r.exc_epc;
        exc_badaddr = r.exc_bad;
        exc_bd      = r.bd;
        eret        = r.eret;
        hw_int      = r.hw_int;
        read_addr_1 = r.ra1;
        read_addr_2 = r.ra2;
    endtask

    task automatic check_row(string name, row_t r);
        if (r.chk) begin
            check_word({name, " rd1"}, predict_read(r, r.ra1, 1'b0), read_data_1);
            check_word({name, " rd2"}, predict_read(r, r.ra2, 1'b1), read_data_2);
        end
        check_word({name, " status"}, status_word(), status);
        check_word({name, " cause"}, cause_word(), cause);
        check_word({name, " epc"}, sh_epc, epc);
        check_flag({name, " irq"}, irq_level(), irq_pending);
    endtask

    task automatic build_table();
        row_t   r;
        word_t  t;
        raddr_t a;
        raddr_t prev;
        prev = '0;
        // random gpr writes, each read back on both ports one row later
        for (int i = 0; i < 16; i++) begin
            t = lfsr_bits(5);
            a = {2'b00, t[4:0]};
            add_row("gpr_random", make_row(1'b1, a, lfsr_bits(32), prev, prev, 6'h00));
            prev = a;
        end
        add_row("gpr_readback", make_row(1'b0, '0, '0, prev, prev, 6'h00));
        add_row("r0_write", make_row(1'b1, 7'h00, 32'hdead_beef, 7'h00, 7'h00, 6'h00));
        add_row("r0_read", make_row(1'b0, '0, '0, 7'h00, 7'h00, 6'h00));
        add_row("fwd_gpr", make_row(1'b1, 7'h09, 32'h1234_5678, 7'h09, 7'h09, 6'h00));
        // hi/lo, 7'h41 aliases lo
        add_row("hi_write", make_row(1'b1, 7'h7f, 32'hcafe_0001, 7'h7f, 7'h7f, 6'h00));
        add_row("lo_alias", make_row(1'b1, 7'h41, 32'hcafe_0002, 7'h7f, 7'h41, 6'h00));
        add_row("hilo_read", make_row(1'b0, '0, '0, 7'h7f, 7'h40, 6'h00));
        r = make_row(1'b0, '0, '0, 7'h7f, 7'h40, 6'h00);
        r.hl_we   = 1'b1;
        r.hl_data = {lfsr_bits(32), lfsr_bits(32)};
        add_row("hl_wide", r);
        // wide result and mthi together
        r = make_row(1'b1, 7'h7f, 32'h9999_0000, 7'h7f, 7'h40, 6'h00);
        r.hl_we   = 1'b1;
        r.hl_data = 64'h1111_2222_3333_4444;
        add_row("hl_over_single", r);
        add_row("hl_stored", make_row(1'b0, '0, '0, 7'h7f, 7'h40, 6'h00));
        // mtc0, ie set and im bit 2
        add_row("mtc0_status", make_row(1'b1, 7'h2c, 32'h0000_0401, '0, 7'h2c, 6'h00));
        add_row("mtc0_epc", make_row(1'b1, 7'h2e, 32'hbfc0_0180, 7'h2c, 7'h2c, 6'h00));
        add_row("mtc0_cause", make_row(1'b1, 7'h2d, 32'h0000_0300, 7'h2e, 7'h2e, 6'h00));
        add_row("cp0_read", make_row(1'b0, '0, '0, 7'h2d, 7'h2d, 6'h00));
        // address error, mtc0 to epc loses
        r = exc_row(1'b1, EXC_ADEL, 32'h8000_0100, 32'h1234_0003, 1'b1, 1'b0, 7'h28);
        r.we    = 1'b1;
        r.waddr = 7'h2e;
        r.wdata = 32'hffff_ffff;
        add_row("exc_adel", r);
        add_row("exc_entered", make_row(1'b0, '0, '0, 7'h2e, 7'h28, 6'h00));
        add_row("eret", exc_row(1'b0, EXC_INT, '0, '0, 1'b0, 1'b1, 7'h2c));
        // eret ignored, badvaddr kept
        add_row("exc_sys_eret",
                exc_row(1'b1, EXC_SYS, 32'h8000_0200, 32'h5555_aaaa, 1'b0, 1'b1, 7'h28));
        add_row("eret_clear", exc_row(1'b0, EXC_INT, '0, '0, 1'b0, 1'b1, 7'h28));
        // hw_int bit 0 is ip bit 2
        add_row("int_assert", make_row(1'b0, '0, '0, '0, 7'h2d, 6'h01));
        add_row("int_pending", make_row(1'b0, '0, '0, '0, 7'h2d, 6'h01));
        add_row("int_set_exl", make_row(1'b1, 7'h2c, 32'h0000_0403, '0, 7'h2c, 6'h01));
        add_row("int_held_exl", make_row(1'b0, '0, '0, '0, 7'h2c, 6'h01));
        add_row("int_clear_exl", make_row(1'b1, 7'h2c, 32'h0000_0401, '0, 7'h2c, 6'h01));
        add_row("int_again", make_row(1'b0, '0, '0, '0, 7'h2d, 6'h01));
        add_row("int_mask_off", make_row(1'b1, 7'h2c, 32'h0000_0001, '0, 7'h2c, 6'h01));
        add_row("int_masked", make_row(1'b0, '0, '0, '0, 7'h2d, 6'h01));
    endtask

    initial begin
        int wait_cnt;
        apply_row(make_row(1'b0, '0, '0, '0, '0, 6'h00));
        // cp0 state after reset
        sh_gpr[0] = '0;
        sh_ie     = 1'b0;
        sh_exl    = 1'b0;
        sh_bd     = 1'b0;
        sh_im     = '0;
        sh_iphw   = '0;
        sh_ipsw   = '0;
        sh_exc    = EXC_INT;
        sh_epc    = '0;
        sh_bva    = '0;
        build_table();
        wait_cnt = 0;
        while (reset) begin
            @(posedge clk);
            wait_cnt++;
            if (wait_cnt > 64) begin
                $display("timeout: reset was not released");
                stop_run();
            end
        end
        // drive 1 ns after the edge, check mid-cycle
        foreach (row_q[i]) begin
            @(posedge clk);
            #1;
            apply_row(row_q[i]);
            #2;
            check_row(name_q[i], row_q[i]);
            shadow_step(row_q[i]);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

/* write_port.sv */
`timescale 1ns/10ps

module write_port (
    input  logic             write_en,
    input  regs_pkg::raddr_t write_addr,
    input  regs_pkg::word_t  write_data,
    input  logic             hl_we,
    input  regs_pkg::hl_t    hl_data,
    reg_wr_if.src            wr
);
    import regs_pkg::*;

    logic addr_zero;

    // r0 writes never reach the stores
    assign addr_zero = (write_addr == '0);

    always_comb begin
        // single write only when enabled and not r0
        wr.we   = write_en & ~addr_zero;
        // class decoded once, stores trust it
        wr.cls  = class_of(write_addr);
        wr.addr = write_addr;
        wr.data = write_data;
    end

    // wide result passes straight on
    assign wr.hl_we   = hl_we;
    assign wr.hl_data = hl_data;

endmodule
